//--- Bender.yml
package:
  name: tomasulo_core

sources:
  - include_dirs:
      - include
    files:
      - verilog/lc3b_pkg.sv
      - verilog/reg_status.sv
      - verilog/issue_unit.sv
      - verilog/alu_stations.sv
      - verilog/reorder_buffer.sv
      - verilog/tomasulo_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tomasulo_props.sv
      - bench/tomasulo_tb.sv

//--- bench/tomasulo_props.sv
`timescale 1ns/1ns
`default_nettype none

module tomasulo_props
(
	input wire logic clk,
	input wire logic reset,
	input wire logic instr_valid,
	input wire logic instr_credit,
	input wire logic cdb_valid,
	input wire logic commit_valid
);

localparam int commit_window = 64; // Enough for a full ROB of dependent ops

logic [15:0] received;
logic [15:0] returned;
int failures = 0;

always_ff @(posedge clk)
begin
	if (reset)
	begin
		received <= '0;
		returned <= '0;
	end
	else
	begin
		received <= received + 16'(instr_valid);
		returned <= returned + 16'(instr_credit);
	end
end

quiet_after_reset: assert property (@(posedge clk) reset |=> !instr_credit && !commit_valid)
else
begin
	failures++;
	$error("credit or commit in the cycle after reset");
end

// An issue only ever frees an instruction already received
credits_bounded: assert property (@(posedge clk) disable iff (reset)
	(returned + 16'(instr_credit)) <= received)
else
begin
	failures++;
	$error("more credits returned than instructions received");
end

result_commits: assert property (@(posedge clk) disable iff (reset)
	cdb_valid |-> ##[1:commit_window] commit_valid)
else
begin
	failures++;
	$error("CDB result without a later commit");
end

endmodule

bind tomasulo_top tomasulo_props props_i (.*);

`default_nettype wire

//--- bench/tomasulo_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "tomasulo_config.svh"

module tomasulo_tb import lc3b_pkg::*;
();

localparam int reset_cycles = 8;
localparam int cycles_per_instr = 30;

logic clk;
logic reset;
logic instr_valid;
lc3b_instr_u instr;
lc3b_word instr_pc;
logic instr_credit;
logic commit_valid;
lc3b_reg commit_reg;
lc3b_word commit_value;

lc3b_word model [8]; // Registers as in-order execution leaves them
lc3b_reg exp_reg [$];
lc3b_word exp_value [$];
string exp_test [$];
int credits = 0;
int sent = 0;
int cycles = 0;
lc3b_word pc;

tomasulo_top dut_i (.*);

initial
begin
	clk = 1'b0;
	forever #20 clk = ~clk;
end

task automatic stop_run(input string why);
	$display("%s", why);
	$display("tests failed");
	$fatal(1, "simulation stopped");
endtask

task automatic report_mismatch(input string test, input string field,
	input lc3b_word expected, input lc3b_word actual);
	$display("Fail %s %s expected %h actual %h", test, field, expected, actual);
	$display("tests failed");
	$fatal(1, "commit mismatch");
endtask

always @(posedge clk)
begin
	cycles++;
	if (cycles > reset_cycles + cycles_per_instr * (sent + 1))
		stop_run("Timeout: commits stopped arriving within the cycle limit");
end

// Commit outputs are registered, so mid-cycle they are settled
always @(negedge clk)
begin
	if (commit_valid)
	begin
		assert (exp_reg.size() != 0) else stop_run("Commit seen with no instruction outstanding");
		assert (commit_reg == exp_reg[0])
		else
			report_mismatch(exp_test[0], "register", exp_reg[0], commit_reg);
		assert (commit_value == exp_value[0])
		else
			report_mismatch(exp_test[0], "value", exp_value[0], commit_value);
		void'(exp_reg.pop_front());
		void'(exp_value.pop_front());
		void'(exp_test.pop_front());
	end
end

function automatic lc3b_instr_u reg_form(input lc3b_opcode op, input lc3b_reg d,
	input lc3b_reg s1, input lc3b_reg s2);
	return {op, d, s1, 3'b000, s2};
endfunction

function automatic lc3b_instr_u imm_form(input lc3b_opcode op, input lc3b_reg d,
	input lc3b_reg s1, input logic [4:0] imm);
	return {op, d, s1, 1'b1, imm};
endfunction

function automatic lc3b_instr_u not_form(input lc3b_reg d, input lc3b_reg s1);
	return {op_not, d, s1, 6'b111111};
endfunction

function automatic lc3b_instr_u lea_form(input lc3b_reg d, input logic [8:0] off);
	return {op_lea, d, off};
endfunction

function automatic lc3b_instr_u random_instr();
	lc3b_opcode op;
	lc3b_reg d;
	lc3b_reg s1;
	lc3b_reg s2;
	d = lc3b_reg'($urandom_range(7));
	s1 = lc3b_reg'($urandom_range(7));
	s2 = lc3b_reg'($urandom_range(7));
	case ($urandom_range(3))
		0: op = op_add;
		1: op = op_and;
		2: op = op_not;
		default: op = op_lea;
	endcase
	if (op == op_lea)
		return lea_form(d, 9'($urandom()));
	if (op == op_not)
		return not_form(d, s1);
	if ($urandom_range(1) == 1)
		return imm_form(op, d, s1, 5'($urandom()));
	return reg_form(op, d, s1, s2);
endfunction

// One falling edge, with the credit of this cycle taken back
task automatic tick();
	@(negedge clk);
	instr_valid = 1'b0;
	if (instr_credit)
		credits++;
	assert (credits <= `INSTR_CREDITS)
	else
		stop_run("Credit returned for an instruction never sent");
endtask

task automatic send_instr(input string test, input lc3b_instr_u word);
	lc3b_word a;
	lc3b_word b;
	lc3b_word result;
	a = model[word.opr.sr1];
	if (word.opr.imm_flag)
		b = lc3b_word'($signed(word.opr.imm5_sr2));
	else
		b = model[word.opr.imm5_sr2[2:0]];
	case (word.opr.opcode)
		op_add: result = a + b;
		op_and: result = a & b;
		op_not: result = ~a;
		default: result = pc + 16'd2 + lc3b_word'($signed(word.pcoff.offset9) * 2);
	endcase
	while (credits == 0)
		tick();
	instr_valid = 1'b1;
	instr = word;
	instr_pc = pc;
	credits--;
	sent++;
	model[word.opr.dest] = result; // Same dest bits in both forms
	exp_reg.push_back(word.opr.dest);
	exp_value.push_back(result);
	exp_test.push_back(test);
	pc += 16'd2;
	tick();
endtask

task automatic drain();
	while (exp_reg.size() != 0)
		tick();
endtask

initial
begin
	void'($urandom(18337));
	reset = 1'b1;
	instr_valid = 1'b0;
	instr = '0;
	instr_pc = '0;
	pc = 16'h3000;
	for (int i = 0; i < 8; i++)
		model[i] = '0;
	repeat (reset_cycles) @(negedge clk);
	reset = 1'b0;
	credits = `INSTR_CREDITS;
	repeat (5) tick(); // Idle, nothing may commit

	send_instr("reset", imm_form(op_add, 3'd1, 3'd0, 5'd0));
	send_instr("reset", reg_form(op_and, 3'd2, 3'd3, 3'd4));
	drain();

	send_instr("independent", imm_form(op_add, 3'd3, 3'd0, 5'd9));
	send_instr("independent", imm_form(op_add, 3'd4, 3'd0, 5'b10011)); // -13
	drain();
	send_instr("independent", reg_form(op_add, 3'd5, 3'd3, 3'd4));
	send_instr("independent", reg_form(op_and, 3'd6, 3'd3, 3'd4));
	send_instr("independent", not_form(3'd7, 3'd3));
	send_instr("independent", imm_form(op_and, 3'd1, 3'd4, 5'b01110));
	send_instr("independent", imm_form(op_add, 3'd2, 3'd3, 5'b11111));
	send_instr("independent", not_form(3'd0, 3'd4));
	drain();

	// Each op reads the previous result
	for (int i = 0; i < 4; i++)
		send_instr("chain", imm_form(op_add, 3'd1, 3'd1, 5'd3));
	send_instr("chain", reg_form(op_add, 3'd2, 3'd1, 3'd1));
	send_instr("chain", not_form(3'd2, 3'd2));
	send_instr("chain", reg_form(op_and, 3'd3, 3'd2, 3'd1));
	send_instr("chain", reg_form(op_add, 3'd1, 3'd3, 3'd2));
	drain();

	send_instr("lea", lea_form(3'd4, 9'd25));
	drain();
	send_instr("lea", lea_form(3'd5, 9'h1f0)); // Negative offset
	send_instr("lea", reg_form(op_add, 3'd6, 3'd5, 3'd4)); // R5 still only in the ROB
	drain();

	// Dependent ADDs leave the last reader parked in station 2
	for (int k = 0; k < 3; k++)
		send_instr("burst", imm_form(op_add, 3'd1, 3'd1, 5'd3));
	send_instr("burst", reg_form(op_add, 3'd3, 3'd1, 3'd1));
	// Ready ops keep winning stations 0 and 1 until the ROB fills
	for (int k = 0; k < 10; k++)
		send_instr("burst", imm_form(op_add, lc3b_reg'(4 + k % 4), 3'd0, 5'(k + 1)));
	drain();

	for (int n = 0; n < 200; n++)
		send_instr("random", random_instr());
	drain();

	repeat (20) tick(); // A stray commit would trip the checker
	assert (exp_reg.size() == 0) else stop_run("Expected commits never arrived");
	if (dut_i.props_i.failures == 0)
	begin
		$display("all tests passed");
		$finish;
	end
	else
		stop_run("Protocol assertions failed during the run");
end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
verilog/lc3b_pkg.sv
verilog/reg_status.sv
verilog/issue_unit.sv
verilog/alu_stations.sv
verilog/reorder_buffer.sv
verilog/tomasulo_top.sv
bench/tomasulo_props.sv
bench/tomasulo_tb.sv

//--- include/tomasulo_config.svh
`ifndef TOMASULO_CONFIG_SVH
`define TOMASULO_CONFIG_SVH

// Reorder buffer entries, kept a power of two so pointers wrap
`define ROB_DEPTH 8

// Width of a reorder buffer index
`define ROB_TAG_W 3

// Instruction buffer depth, also the credits held by the source
`define INSTR_CREDITS 2

`endif

//--- verilog/alu_stations.sv
`timescale 1ns/1ns
`default_nettype none

`include "tomasulo_config.svh"

module alu_stations import lc3b_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic rs_write,
	input wire lc3b_opcode rs_op,
	input wire lc3b_word rs_vj,
	input wire lc3b_word rs_vk,
	input wire rob_tag rs_qj,
	input wire rob_tag rs_qk,
	input wire logic rs_j_ready,
	input wire logic rs_k_ready,
	input wire rob_tag rs_dest,
	output logic rs_full,
	output logic cdb_valid,
	output rob_tag cdb_tag,
	output lc3b_word cdb_value
);

localparam int n_rs = 3;

logic [n_rs-1:0] busy;
lc3b_opcode op [n_rs];
lc3b_word vj [n_rs];
lc3b_word vk [n_rs];
rob_tag qj [n_rs];
rob_tag qk [n_rs];
logic j_ready [n_rs];
logic k_ready [n_rs];
rob_tag dest [n_rs];

logic [1:0] free_idx;
logic [1:0] disp_idx;
logic dispatch;
lc3b_word alu_result;

// Scan from the top so the lowest index wins
always_comb
begin
	free_idx = '0;
	disp_idx = '0;
	dispatch = 1'b0;
	for (int i = n_rs - 1; i >= 0; i--)
	begin
		if (!busy[i])
			free_idx = 2'(i);
		if (busy[i] && j_ready[i] && k_ready[i])
		begin
			dispatch = 1'b1;
			disp_idx = 2'(i);
		end
	end
end

assign rs_full = &busy;

always_comb
begin
	case (op[disp_idx])
		op_add: alu_result = vj[disp_idx] + vk[disp_idx];
		op_and: alu_result = vj[disp_idx] & vk[disp_idx];
		default: alu_result = vj[disp_idx] ^ vk[disp_idx]; // NOT
	endcase
end

always_ff @(posedge clk)
begin
	if (reset)
	begin
		busy <= '0;
		cdb_valid <= 1'b0;
	end
	else
	begin
		if (rs_write)
			busy[free_idx] <= 1'b1;
		if (dispatch)
			busy[disp_idx] <= 1'b0; // Never the slot being written
		cdb_valid <= dispatch;
	end
end

always_ff @(posedge clk)
begin
	for (int i = 0; i < n_rs; i++)
	begin
		if (rs_write && 2'(i) == free_idx)
		begin
			op[i] <= rs_op;
			vj[i] <= rs_vj;
			vk[i] <= rs_vk;
			qj[i] <= rs_qj;
			qk[i] <= rs_qk;
			j_ready[i] <= rs_j_ready;
			k_ready[i] <= rs_k_ready;
			dest[i] <= rs_dest;
		end
		else
		begin
			if (!j_ready[i] && cdb_valid && qj[i] == cdb_tag)
			begin
				vj[i] <= cdb_value;
				j_ready[i] <= 1'b1;
			end
			if (!k_ready[i] && cdb_valid && qk[i] == cdb_tag)
			begin
				vk[i] <= cdb_value;
				k_ready[i] <= 1'b1;
			end
		end
	end
	if (dispatch)
	begin
		cdb_tag <= dest[disp_idx];
		cdb_value <= alu_result;
	end
end

endmodule

`default_nettype wire

//--- verilog/issue_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "tomasulo_config.svh"

module issue_unit import lc3b_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic instr_valid,
	input wire lc3b_instr_u instr,
	input wire lc3b_word instr_pc,
	input wire lc3b_word sr1_data,
	input wire lc3b_word sr2_data,
	input wire logic sr1_busy,
	input wire logic sr2_busy,
	input wire rob_tag sr1_tag,
	input wire rob_tag sr2_tag,
	input wire logic rob_full,
	input wire rob_tag alloc_tag,
	input wire logic sr1_rob_done,
	input wire logic sr2_rob_done,
	input wire lc3b_word sr1_rob_value,
	input wire lc3b_word sr2_rob_value,
	input wire logic rs_full,
	input wire logic cdb_valid,
	input wire rob_tag cdb_tag,
	input wire lc3b_word cdb_value,
	output logic instr_credit,
	output lc3b_reg sr1,
	output lc3b_reg sr2,
	output logic rename_valid,
	output lc3b_reg rename_reg,
	output rob_tag rename_tag,
	output logic alloc_valid,
	output lc3b_reg alloc_dest,
	output logic alloc_done,
	output lc3b_word alloc_value,
	output logic rs_write,
	output lc3b_opcode rs_op,
	output lc3b_word rs_vj,
	output lc3b_word rs_vk,
	output rob_tag rs_qj,
	output rob_tag rs_qk,
	output logic rs_j_ready,
	output logic rs_k_ready
);

localparam int ptr_w = (`INSTR_CREDITS > 1) ? $clog2(`INSTR_CREDITS) : 1;

lc3b_instr_u fifo_instr [`INSTR_CREDITS];
lc3b_word fifo_pc [`INSTR_CREDITS];
logic [ptr_w-1:0] rd_ptr;
logic [ptr_w-1:0] wr_ptr;
logic [$clog2(`INSTR_CREDITS+1)-1:0] fill;

lc3b_instr_u head_instr;
lc3b_word head_pc;
lc3b_opcode opcode;
logic is_alu;
logic is_lea;
logic issue;
lc3b_word imm5_sext;
lc3b_word offset9_adj;

function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
	return (p == ptr_w'(`INSTR_CREDITS - 1)) ? '0 : p + 1'b1;
endfunction

// Register, then CDB, then a finished ROB entry, else wait on the tag
function automatic void resolve(input logic busy, input rob_tag tag, input lc3b_word reg_data,
	input logic rob_done, input lc3b_word rob_value, output lc3b_word value, output logic ready);
	value = reg_data;
	ready = 1'b1;
	if (busy)
	begin
		if (cdb_valid && cdb_tag == tag)
			value = cdb_value;
		else if (rob_done)
			value = rob_value;
		else
		begin
			value = '0;
			ready = 1'b0;
		end
	end
endfunction

// Source never sends without a credit, so no full check on push
always_ff @(posedge clk)
begin
	if (reset)
	begin
		rd_ptr <= '0;
		wr_ptr <= '0;
		fill <= '0;
	end
	else
	begin
		if (instr_valid)
			wr_ptr <= next_ptr(wr_ptr);
		if (issue)
			rd_ptr <= next_ptr(rd_ptr);
		case ({instr_valid, issue})
			2'b10: fill <= fill + 1'b1;
			2'b01: fill <= fill - 1'b1;
			default: ;
		endcase
	end
end

always_ff @(posedge clk)
begin
	if (instr_valid)
	begin
		fifo_instr[wr_ptr] <= instr;
		fifo_pc[wr_ptr] <= instr_pc;
	end
end

assign head_instr = fifo_instr[rd_ptr];
assign head_pc = fifo_pc[rd_ptr];
assign opcode = head_instr.opr.opcode;
assign is_alu = (opcode == op_add) || (opcode == op_and) || (opcode == op_not);
assign is_lea = (opcode == op_lea);

assign imm5_sext = {{11{head_instr.opr.imm5_sr2[4]}}, head_instr.opr.imm5_sr2};
assign offset9_adj = {{6{head_instr.pcoff.offset9[8]}}, head_instr.pcoff.offset9, 1'b0};

// Unknown opcodes drain without effect
assign issue = (fill != 0) && !rob_full && !(is_alu && rs_full);
assign instr_credit = issue;

assign sr1 = head_instr.opr.sr1;
assign sr2 = head_instr.opr.imm5_sr2[2:0];

assign alloc_valid = issue && (is_alu || is_lea);
assign alloc_dest = head_instr.opr.dest; // Same bits in both forms
assign alloc_done = is_lea; // LEA needs no execution
assign alloc_value = head_pc + 16'd2 + offset9_adj;

assign rename_valid = alloc_valid;
assign rename_reg = alloc_dest;
assign rename_tag = alloc_tag;

assign rs_write = issue && is_alu;
assign rs_op = opcode;
assign rs_qj = sr1_tag;
assign rs_qk = sr2_tag;

always_comb
begin
	resolve(sr1_busy, sr1_tag, sr1_data, sr1_rob_done, sr1_rob_value, rs_vj, rs_j_ready);
	if (opcode == op_not)
	begin
		rs_vk = '1; // NOT runs as XOR with all ones
		rs_k_ready = 1'b1;
	end
	else if (head_instr.opr.imm_flag)
	begin
		rs_vk = imm5_sext;
		rs_k_ready = 1'b1;
	end
	else
		resolve(sr2_busy, sr2_tag, sr2_data, sr2_rob_done, sr2_rob_value, rs_vk, rs_k_ready);
end

endmodule

`default_nettype wire

//--- verilog/lc3b_pkg.sv
`default_nettype none

`include "tomasulo_config.svh"

package lc3b_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [`ROB_TAG_W-1:0] rob_tag;

	typedef enum logic [3:0] {
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_not = 4'b1001,
		op_lea = 4'b1110
	} lc3b_opcode;

	// ADD, AND, NOT
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dest;
		lc3b_reg sr1;
		logic imm_flag;
		logic [4:0] imm5_sr2; // sr2 sits in the low three bits
	} lc3b_operate_t;

	// LEA
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dest;
		logic [8:0] offset9;
	} lc3b_pcoffset_t;

	typedef union packed {
		lc3b_operate_t opr;
		lc3b_pcoffset_t pcoff;
	} lc3b_instr_u;

endpackage

`default_nettype wire

//--- verilog/reg_status.sv
`timescale 1ns/1ns
`default_nettype none

`include "tomasulo_config.svh"

module reg_status import lc3b_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire lc3b_reg sr1,
	input wire lc3b_reg sr2,
	input wire logic rename_valid,
	input wire lc3b_reg rename_reg,
	input wire rob_tag rename_tag,
	input wire logic commit_valid,
	input wire lc3b_reg commit_reg,
	input wire lc3b_word commit_value,
	input wire rob_tag commit_tag,
	output lc3b_word sr1_data,
	output lc3b_word sr2_data,
	output logic sr1_busy,
	output logic sr2_busy,
	output rob_tag sr1_tag,
	output rob_tag sr2_tag
);

lc3b_word regs [8];
logic [7:0] busy;
rob_tag owner [8]; // Latest in-flight writer of each register

always_ff @(posedge clk)
begin
	if (reset)
	begin
		for (int i = 0; i < 8; i++)
			regs[i] <= '0;
		busy <= '0;
	end
	else
	begin
		if (commit_valid)
		begin
			regs[commit_reg] <= commit_value;
			if (owner[commit_reg] == commit_tag) // Younger writer keeps it busy
				busy[commit_reg] <= 1'b0;
		end
		if (rename_valid)
			busy[rename_reg] <= 1'b1; // Rename wins over a same-cycle commit
	end
end

always_ff @(posedge clk)
begin
	if (rename_valid)
		owner[rename_reg] <= rename_tag;
end

assign sr1_data = regs[sr1];
assign sr2_data = regs[sr2];
assign sr1_busy = busy[sr1];
assign sr2_busy = busy[sr2];
assign sr1_tag = owner[sr1];
assign sr2_tag = owner[sr2];

endmodule

`default_nettype wire

//--- verilog/reorder_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "tomasulo_config.svh"

module reorder_buffer import lc3b_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic alloc_valid,
	input wire lc3b_reg alloc_dest,
	input wire logic alloc_done,
	input wire lc3b_word alloc_value,
	input wire rob_tag sr1_tag,
	input wire rob_tag sr2_tag,
	input wire logic cdb_valid,
	input wire rob_tag cdb_tag,
	input wire lc3b_word cdb_value,
	output logic rob_full,
	output rob_tag alloc_tag,
	output logic sr1_rob_done,
	output logic sr2_rob_done,
	output lc3b_word sr1_rob_value,
	output lc3b_word sr2_rob_value,
	output logic commit_valid,
	output lc3b_reg commit_reg,
	output lc3b_word commit_value,
	output rob_tag commit_tag
);

rob_tag head;
rob_tag tail;
logic [`ROB_TAG_W:0] count;
logic retire;

logic [`ROB_DEPTH-1:0] done;
lc3b_reg ent_dest [`ROB_DEPTH];
lc3b_word ent_value [`ROB_DEPTH];

assign rob_full = (count == `ROB_DEPTH);
assign alloc_tag = tail;
assign retire = (count != 0) && done[head];

// A retired slot keeps its value until reallocated, which covers
// readers whose register still shows busy during the commit cycle
assign sr1_rob_done = done[sr1_tag];
assign sr2_rob_done = done[sr2_tag];
assign sr1_rob_value = ent_value[sr1_tag];
assign sr2_rob_value = ent_value[sr2_tag];

always_ff @(posedge clk)
begin
	if (reset)
	begin
		head <= '0;
		tail <= '0;
		count <= '0;
		done <= '0;
		commit_valid <= 1'b0;
	end
	else
	begin
		commit_valid <= retire;
		if (retire)
			head <= head + 1'b1; // Wraps at the power-of-two depth
		if (alloc_valid)
		begin
			tail <= tail + 1'b1;
			done[tail] <= alloc_done;
		end
		if (cdb_valid)
			done[cdb_tag] <= 1'b1;
		case ({alloc_valid, retire})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: ;
		endcase
	end
end

always_ff @(posedge clk)
begin
	if (alloc_valid)
	begin
		ent_dest[tail] <= alloc_dest;
		ent_value[tail] <= alloc_value;
	end
	if (cdb_valid)
		ent_value[cdb_tag] <= cdb_value;
	if (retire)
	begin
		commit_reg <= ent_dest[head];
		commit_value <= ent_value[head];
		commit_tag <= head;
	end
end

endmodule

`default_nettype wire

//--- verilog/tomasulo_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "tomasulo_config.svh"

module tomasulo_top import lc3b_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic instr_valid,
	input wire lc3b_instr_u instr,
	input wire lc3b_word instr_pc,
	output logic instr_credit,
	output logic commit_valid,
	output lc3b_reg commit_reg,
	output lc3b_word commit_value
);

// Register status lookup and rename
lc3b_reg sr1;
lc3b_reg sr2;
lc3b_word sr1_data;
lc3b_word sr2_data;
logic sr1_busy;
logic sr2_busy;
rob_tag sr1_tag;
rob_tag sr2_tag;
logic rename_valid;
lc3b_reg rename_reg;
rob_tag rename_tag;

// Reorder buffer allocation and lookup
logic rob_full;
rob_tag alloc_tag;
logic sr1_rob_done;
logic sr2_rob_done;
lc3b_word sr1_rob_value;
lc3b_word sr2_rob_value;
logic alloc_valid;
lc3b_reg alloc_dest;
logic alloc_done;
lc3b_word alloc_value;
rob_tag commit_tag;

// Stations and CDB
logic rs_full;
logic rs_write;
lc3b_opcode rs_op;
lc3b_word rs_vj;
lc3b_word rs_vk;
rob_tag rs_qj;
rob_tag rs_qk;
logic rs_j_ready;
logic rs_k_ready;
logic cdb_valid;
rob_tag cdb_tag;
lc3b_word cdb_value;

issue_unit issue_unit_i (.*);

reg_status reg_status_i (.*);

alu_stations alu_stations_i
(
	.rs_dest(alloc_tag), // Station result goes to the entry just allocated
	.*
);

reorder_buffer reorder_buffer_i (.*);

endmodule

`default_nettype wire
